// File: pru_consts.svh
`ifndef PRU_CONSTS_SVH
`define PRU_CONSTS_SVH

// Frame geometry, reduced from full VGA so whole frames fit in simulation
`define PRU_FB_W        32
`define PRU_FB_H        24
`define PRU_FB_PIX      (`PRU_FB_W * `PRU_FB_H)
`define PRU_FB_AW       10              // Enough for 768 pixels
`define PRU_IDX_W       2               // Four palette entries
`define PRU_CHAN_W      10

// APB register byte offsets
`define PRU_REG_CTRL    8'h00
`define PRU_REG_POS     8'h04
`define PRU_REG_SIZE    8'h08
`define PRU_REG_COLOR   8'h0C
`define PRU_REG_STATUS  8'h10
`define PRU_REG_PAL0    8'h20           // Entries at 0x20, 0x24, 0x28, 0x2C

// Palette reset values, {red, green, blue}
`define PRU_PAL_RST0    {10'h30f, 10'h30f, 10'h30f}     // Grey background
`define PRU_PAL_RST1    {10'h3ff, 10'h000, 10'h000}
`define PRU_PAL_RST2    {10'h000, 10'h3ff, 10'h000}
`define PRU_PAL_RST3    {10'h200, 10'h000, 10'h3ff}     // Violet

`endif

// File: pru_pkg.sv
`default_nettype none
`include "pru_consts.svh"

package pru_pkg;

    typedef enum logic [1:0] {
        SHAPE_RECT   = 2'd0,
        SHAPE_CIRCLE = 2'd1,
        SHAPE_CLEAR  = 2'd2            // 2'd3 is reserved
    } shape_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_DRAW = 2'd1,
        ST_DONE = 2'd2
    } draw_state_e;

    // Draw command, 37 bits
    typedef struct packed {
        shape_e      shape;
        logic [5:0]  row;              // Top row, or centre row for a circle
        logic [5:0]  col;              // Left column, or centre column
        logic [5:0]  width;
        logic [5:0]  height_radius;    // Height for a rectangle, radius for a circle
        logic [1:0]  color;
        logic [8:0]  padding;          // Kept at zero
    } draw_cmd_t;

    typedef struct packed {
        logic [`PRU_CHAN_W-1:0] red;
        logic [`PRU_CHAN_W-1:0] green;
        logic [`PRU_CHAN_W-1:0] blue;
    } rgb_t;

    typedef struct packed {
        rgb_t rgb;
        logic sof;                     // Pixel (0,0) of a frame
    } pix_out_t;

    typedef rgb_t [3:0] palette_t;

endpackage

`default_nettype wire

// File: pru_apb_regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "pru_consts.svh"

module pru_apb_regs import pru_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             i_psel,
    input  wire             i_penable,
    input  wire             i_pwrite,
    input  wire [7:0]       i_paddr,
    input  wire [31:0]      i_pwdata,
    input  wire             i_busy,
    input  wire             i_done,
    output logic [31:0]     o_prdata,
    output logic            o_pready,
    output logic            o_pslverr,
    output logic            o_start,
    output draw_cmd_t       o_cmd,
    output palette_t        o_palette
);
    logic       access, wr, is_pal, addr_hit, ctrl_wr, ctrl_err;
    logic [5:0] row_q, col_q, width_q, height_q;
    logic [1:0] color_q;
    shape_e     shape_q;
    logic       done_q;
    palette_t   palette_q;

    assign access   = i_psel & i_penable;
    assign wr       = access & i_pwrite;
    assign is_pal   = (i_paddr & 8'hF3) == `PRU_REG_PAL0;
    assign ctrl_wr  = wr & (i_paddr == `PRU_REG_CTRL);
    assign ctrl_err = ctrl_wr & (i_busy | (i_pwdata[2:1] == 2'b11));   // Busy or reserved shape

    assign o_pready  = 1'b1;
    assign o_pslverr = access & (~addr_hit | ctrl_err);
    assign o_start   = ctrl_wr & i_pwdata[0] & ~ctrl_err;
    assign o_palette = palette_q;

    // Read mux and address decode
    always_comb begin
        o_prdata = '0;
        addr_hit = 1'b1;
        if (is_pal) begin
            o_prdata = {2'b00, palette_q[i_paddr[3:2]]};
        end else begin
            case (i_paddr)
                `PRU_REG_CTRL:   o_prdata = {29'd0, shape_q, 1'b0};
                `PRU_REG_POS:    o_prdata = {10'd0, row_q, 10'd0, col_q};     // Row in 21:16
                `PRU_REG_SIZE:   o_prdata = {10'd0, height_q, 10'd0, width_q};
                `PRU_REG_COLOR:  o_prdata = {30'd0, color_q};
                `PRU_REG_STATUS: o_prdata = {30'd0, done_q, i_busy};
                default:         addr_hit = 1'b0;
            endcase
        end
    end

    always_comb begin
        o_cmd               = '0;
        o_cmd.shape         = shape_e'(i_pwdata[2:1]);    // Shape comes with the start write
        o_cmd.row           = row_q;
        o_cmd.col           = col_q;
        o_cmd.width         = width_q;
        o_cmd.height_radius = height_q;
        o_cmd.color         = color_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_q     <= '0;
            col_q     <= '0;
            width_q   <= '0;
            height_q  <= '0;
            color_q   <= '0;
            shape_q   <= SHAPE_RECT;
            done_q    <= 1'b0;
            palette_q <= {`PRU_PAL_RST3, `PRU_PAL_RST2, `PRU_PAL_RST1, `PRU_PAL_RST0};
        end else begin
            if (o_start) begin
                done_q <= 1'b0;
            end else if (i_done) begin
                done_q <= 1'b1;         // Sticky until the next start
            end
            if (wr && !o_pslverr) begin
                if (is_pal) begin
                    palette_q[i_paddr[3:2]] <= i_pwdata[29:0];
                end else begin
                    case (i_paddr)
                        `PRU_REG_CTRL: shape_q <= shape_e'(i_pwdata[2:1]);
                        `PRU_REG_POS: begin
                            row_q <= i_pwdata[21:16];
                            col_q <= i_pwdata[5:0];
                        end
                        `PRU_REG_SIZE: begin
                            height_q <= i_pwdata[21:16];
                            width_q  <= i_pwdata[5:0];
                        end
                        `PRU_REG_COLOR: color_q <= i_pwdata[1:0];
                        default: ;                      // STATUS is read only
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: pru_raster.sv
`timescale 1ns/1ns
`default_nettype none
`include "pru_consts.svh"

module pru_raster import pru_pkg::*; (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     i_start,
    input  wire draw_cmd_t          i_cmd,
    output logic                    o_busy,
    output logic                    o_done,
    output logic                    o_we,
    output logic [`PRU_FB_AW-1:0]   o_waddr,
    output logic [`PRU_IDX_W-1:0]   o_wdata
);
    draw_state_e        state_q;
    draw_cmd_t          cmd_q, cmd_cur;
    logic               accept, empty_rect, in_frame, in_shape;
    logic signed [7:0]  r_q, c_q;                    // Walk position, may go negative
    logic signed [7:0]  ctr_r, ctr_c, size_w, size_h;
    logic signed [7:0]  r_first, c_first, r_last, c_last;
    logic signed [7:0]  dr, dc;
    logic signed [15:0] dist2, rad2;

    assign accept  = (state_q == ST_IDLE) & i_start;
    assign cmd_cur = (state_q == ST_IDLE) ? i_cmd : cmd_q;   // Bounds valid on the start cycle

    assign ctr_r  = $signed({2'b00, cmd_cur.row});
    assign ctr_c  = $signed({2'b00, cmd_cur.col});
    assign size_w = $signed({2'b00, cmd_cur.width});
    assign size_h = $signed({2'b00, cmd_cur.height_radius});

    assign empty_rect = (cmd_cur.shape == SHAPE_RECT) &&
                        (cmd_cur.width == '0 || cmd_cur.height_radius == '0);

    // Bounding box of the current shape
    always_comb begin
        case (cmd_cur.shape)
            SHAPE_CIRCLE: begin
                r_first = ctr_r - size_h;
                c_first = ctr_c - size_h;
                r_last  = ctr_r + size_h;
                c_last  = ctr_c + size_h;
            end
            SHAPE_CLEAR: begin
                r_first = '0;
                c_first = '0;
                r_last  = 8'(`PRU_FB_H - 1);
                c_last  = 8'(`PRU_FB_W - 1);
            end
            default: begin
                r_first = ctr_r;
                c_first = ctr_c;
                r_last  = ctr_r + size_h - 8'sd1;
                c_last  = ctr_c + size_w - 8'sd1;
            end
        endcase
    end

    assign dr    = r_q - ctr_r;
    assign dc    = c_q - ctr_c;
    assign dist2 = dr * dr + dc * dc;
    assign rad2  = size_h * size_h;

    assign in_frame = (r_q >= 0) && (r_q < `PRU_FB_H) && (c_q >= 0) && (c_q < `PRU_FB_W);
    assign in_shape = (cmd_q.shape != SHAPE_CIRCLE) || (dist2 <= rad2);

    assign o_busy  = (state_q != ST_IDLE);                // Through the done cycle too
    assign o_done  = (state_q == ST_DONE);
    assign o_we    = (state_q == ST_DRAW) & in_frame & in_shape;
    assign o_waddr = `PRU_FB_AW'(r_q * `PRU_FB_W + c_q);
    assign o_wdata = (cmd_q.shape == SHAPE_CLEAR) ? '0 : cmd_q.color;   // Clear paints entry 0

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= i_cmd;
        end
    end

    // Row-major walk, one position per clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            r_q     <= '0;
            c_q     <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q <= empty_rect ? ST_DONE : ST_DRAW;
                        r_q     <= r_first;
                        c_q     <= c_first;
                    end
                end
                ST_DRAW: begin
                    if (c_q == c_last) begin
                        c_q <= c_first;
                        if (r_q == r_last) begin
                            state_q <= ST_DONE;
                        end else begin
                            r_q <= r_q + 8'sd1;
                        end
                    end else begin
                        c_q <= c_q + 8'sd1;
                    end
                end
                default: state_q <= ST_IDLE;        // ST_DONE lasts one cycle
            endcase
        end
    end

endmodule

`default_nettype wire

// File: pru_frame_buf.sv
`timescale 1ns/1ns
`default_nettype none
`include "pru_consts.svh"

module pru_frame_buf (
    input  wire                     clk,
    input  wire                     i_we,
    input  wire [`PRU_FB_AW-1:0]    i_waddr,
    input  wire [`PRU_IDX_W-1:0]    i_wdata,
    input  wire [`PRU_FB_AW-1:0]    i_raddr,
    output logic [`PRU_IDX_W-1:0]   o_rdata
);
    // One colour index per pixel, row-major
    logic [`PRU_IDX_W-1:0] mem [0:`PRU_FB_PIX-1] = '{default: '0};

    // Write port
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // Registered read, sees the old word on a same-address write
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_raddr];
    end

endmodule

`default_nettype wire

// File: pru_scanout.sv
`timescale 1ns/1ns
`default_nettype none
`include "pru_consts.svh"

module pru_scanout import pru_pkg::*; (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire [`PRU_IDX_W-1:0]    i_rdata,
    input  wire palette_t           i_palette,
    input  wire                     i_pix_ready,
    output logic [`PRU_FB_AW-1:0]   o_raddr,
    output logic                    o_pix_valid,
    output pix_out_t                o_pix
);
    logic [`PRU_FB_AW-1:0] addr_q, addr_inc;
    logic                  pend_q;           // i_rdata holds the pixel at addr_q
    logic                  out_free, load;

    assign addr_inc = (addr_q == `PRU_FB_AW'(`PRU_FB_PIX - 1)) ? '0 : addr_q + 1'b1;
    assign out_free = ~o_pix_valid | i_pix_ready;
    assign load     = pend_q & out_free;

    // Read ahead only when the pending pixel moves to the output
    assign o_raddr = load ? addr_inc : addr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q      <= '0;
            pend_q      <= 1'b0;
            o_pix_valid <= 1'b0;
        end else begin
            pend_q <= 1'b1;                  // Read port returns o_raddr every cycle
            if (load) begin
                addr_q      <= addr_inc;
                o_pix_valid <= 1'b1;
            end else if (i_pix_ready) begin
                o_pix_valid <= 1'b0;
            end
        end
    end

    // Palette lookup into the output register, held under back-pressure
    always_ff @(posedge clk) begin
        if (load) begin
            o_pix.rgb <= i_palette[i_rdata];
            o_pix.sof <= (addr_q == '0);
        end
    end

endmodule

`default_nettype wire

// File: pru_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "pru_consts.svh"

module pru_top import pru_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    // APB slave
    input  wire             i_psel,
    input  wire             i_penable,
    input  wire             i_pwrite,
    input  wire [7:0]       i_paddr,
    input  wire [31:0]      i_pwdata,
    output logic [31:0]     o_prdata,
    output logic            o_pready,
    output logic            o_pslverr,
    // Pixel stream
    output logic            o_pix_valid,
    output pix_out_t        o_pix,
    input  wire             i_pix_ready
);
    logic                   start, busy, done, we;
    draw_cmd_t              cmd;
    palette_t               palette;
    logic [`PRU_FB_AW-1:0]  waddr, raddr;
    logic [`PRU_IDX_W-1:0]  wdata, rdata;

    pru_apb_regs pru_apb_regs_inst (
        .clk, .rst_n,
        .i_psel, .i_penable, .i_pwrite, .i_paddr, .i_pwdata,
        .i_busy(busy), .i_done(done),
        .o_prdata, .o_pready, .o_pslverr,
        .o_start(start), .o_cmd(cmd), .o_palette(palette)
    );

    pru_raster pru_raster_inst (
        .clk, .rst_n,
        .i_start(start), .i_cmd(cmd),
        .o_busy(busy), .o_done(done),
        .o_we(we), .o_waddr(waddr), .o_wdata(wdata)
    );

    pru_frame_buf pru_frame_buf_inst (
        .clk,
        .i_we(we), .i_waddr(waddr), .i_wdata(wdata),
        .i_raddr(raddr), .o_rdata(rdata)
    );

    pru_scanout pru_scanout_inst (
        .clk, .rst_n,
        .i_rdata(rdata), .i_palette(palette), .i_pix_ready,
        .o_raddr(raddr), .o_pix_valid, .o_pix
    );

endmodule

`default_nettype wire

// File: pru_checker.sv
`timescale 1ns/1ns
`default_nettype none
`include "pru_consts.svh"

module pru_checker import pru_pkg::*; (
    input wire                      clk,
    input wire                      rst_n,
    input wire                      i_psel,
    input wire                      i_penable,
    input wire                      i_pslverr,
    input wire                      i_busy,
    input wire                      i_pix_valid,
    input wire                      i_pix_ready,
    input wire pix_out_t            i_pix,
    input wire                      i_we,
    input wire [`PRU_FB_AW-1:0]     i_waddr
);
    int fail_cnt = 0;               // Read by the testbench at the end of the run

    // Stalled pixel keeps its valid and its payload
    a_pix_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (i_pix_valid && !i_pix_ready) |=> (i_pix_valid && $stable(i_pix)))
        else begin
            fail_cnt++;
            $error("o_pix changed or lost valid while the sink stalled");
        end

    a_slverr_access: assert property (@(posedge clk) disable iff (!rst_n)
        i_pslverr |-> (i_psel && i_penable))
        else begin
            fail_cnt++;
            $error("o_pslverr raised outside an APB access cycle");
        end

    // First cycle out of reset
    a_reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> (!i_busy && !i_pix_valid))
        else begin
            fail_cnt++;
            $error("busy or o_pix_valid high in the cycle after reset");
        end

    a_waddr_range: assert property (@(posedge clk) disable iff (!rst_n)
        i_we |-> (i_waddr < `PRU_FB_PIX))
        else begin
            fail_cnt++;
            $error("frame write address beyond the last pixel");
        end

endmodule

`default_nettype wire

// File: tb_pru.sv
`timescale 1ns/1ns
`default_nettype none
`include "pru_consts.svh"

module tb_pru import pru_pkg::*; ();
    localparam int CLK_PERIOD   = 20;
    localparam int FRAME_PIX    = `PRU_FB_PIX;
    localparam int DONE_POLLS   = `PRU_FB_PIX;
    localparam int FRAME_CYCLES = 8 * `PRU_FB_PIX;

    logic        clk, rst_n;
    logic        psel, penable, pwrite, pix_ready;
    logic [7:0]  paddr;
    logic [31:0] pwdata, prdata;
    logic        pready, pslverr, pix_valid;
    pix_out_t    pix;

    logic [1:0]  model [0:`PRU_FB_H-1][0:`PRU_FB_W-1];    // Expected colour index per pixel
    logic [29:0] pal_model [0:3];
    integer      seed = 32'h842f_dd64;
    int          mismatch_cnt, timeout_cnt, assert_cnt;

    pru_top pru_top_inst (
        .clk, .rst_n,
        .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
        .i_paddr(paddr), .i_pwdata(pwdata),
        .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr),
        .o_pix_valid(pix_valid), .o_pix(pix), .i_pix_ready(pix_ready)
    );

    bind pru_top pru_checker pru_checker_inst (
        .clk(clk), .rst_n(rst_n), .i_psel(i_psel), .i_penable(i_penable),
        .i_pslverr(o_pslverr), .i_busy(busy), .i_pix_valid(o_pix_valid),
        .i_pix_ready(i_pix_ready), .i_pix(o_pix), .i_we(we), .i_waddr(waddr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic expect_eq(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            $display("Mismatch %s: expected %h, actual %h", name, exp_val, act_val);
            mismatch_cnt++;
        end
    endtask

    // One APB transfer, setup then access
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(negedge clk);
        psel   = 1'b1;
        pwrite = write;
        paddr  = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);              // Sampled well before the closing edge
        rdata = prdata;
        err   = pslverr;
        expect_eq("o_pready", 32'd1, 32'(pready));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic start_draw(input shape_e shape, input logic [5:0] row, col, w, hr,
                              input logic [1:0] color, output logic err);
        logic [31:0] rd;
        apb_transfer(1'b1, `PRU_REG_POS, {10'd0, row, 10'd0, col}, rd, err);
        apb_transfer(1'b1, `PRU_REG_SIZE, {10'd0, hr, 10'd0, w}, rd, err);
        apb_transfer(1'b1, `PRU_REG_COLOR, {30'd0, color}, rd, err);
        apb_transfer(1'b1, `PRU_REG_CTRL, {29'd0, shape, 1'b1}, rd, err);
    endtask

    // Poll STATUS until the sticky done bit shows up
    task automatic wait_done(output logic saw_busy);
        logic [31:0] st;
        logic        err;
        int          polls;
        st       = '0;
        polls    = 0;
        saw_busy = 1'b0;
        while (!st[1] && polls < DONE_POLLS) begin
            apb_transfer(1'b0, `PRU_REG_STATUS, 32'd0, st, err);
            if (polls == 0) saw_busy = st[0];
            polls++;
        end
        if (!st[1]) begin
            $display("Timeout: STATUS never reported the draw as done");
            timeout_cnt++;
        end
    endtask

    // Shape membership straight from the pixel rules, clipped to the frame
    task automatic model_draw(input shape_e shape, input int row, col, w, hr,
                              input logic [1:0] color);
        logic hit;
        for (int r = 0; r < `PRU_FB_H; r++) begin
            for (int c = 0; c < `PRU_FB_W; c++) begin
                case (shape)
                    SHAPE_RECT:   hit = (r >= row) && (r < row + hr) && (c >= col) && (c < col + w);
                    SHAPE_CIRCLE: hit = (r - row) * (r - row) + (c - col) * (c - col) <= hr * hr;
                    default:      hit = 1'b1;
                endcase
                if (hit) model[r][c] = (shape == SHAPE_CLEAR) ? 2'd0 : color;
            end
        end
    endtask

    task automatic draw_shape(input shape_e shape, input logic [5:0] row, col, w, hr,
                              input logic [1:0] color, output logic saw_busy);
        logic err;
        start_draw(shape, row, col, w, hr, color, err);
        expect_eq("o_pslverr", 32'd0, 32'(err));
        wait_done(saw_busy);
        model_draw(shape, row, col, w, hr, color);
    endtask

    // Collect one frame from sof and compare every pixel
    task automatic check_frame(input logic random_ready);
        logic [31:0] rnd;
        logic [1:0]  idx;
        logic        started;
        int          n, cycles;
        n       = 0;
        cycles  = 0;
        started = 1'b0;
        repeat (2) @(negedge clk);      // Let stale lookups leave the output register
        while (n < FRAME_PIX && cycles < FRAME_CYCLES) begin
            @(negedge clk);
            rnd       = $random(seed);
            pix_ready = random_ready ? rnd[0] : 1'b1;
            #(CLK_PERIOD / 4);
            cycles++;
            if (pix_valid && pix_ready) begin
                started = started | pix.sof;
                if (started) begin
                    idx = model[n / `PRU_FB_W][n % `PRU_FB_W];
                    expect_eq($sformatf("o_pix.sof[%0d]", n), 32'(n == 0), 32'(pix.sof));
                    expect_eq($sformatf("o_pix.rgb[%0d]", n), 32'(pal_model[idx]),
                              32'(pix.rgb));
                    n++;
                end
            end
        end
        pix_ready = 1'b1;
        if (n < FRAME_PIX) begin
            $display("Timeout: only %0d of %0d frame pixels arrived", n, FRAME_PIX);
            timeout_cnt++;
        end
    endtask

    initial begin
        logic [31:0] rd, rnd;
        logic        err, saw_busy;
        rst_n        = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        pix_ready    = 1'b1;
        mismatch_cnt = 0;
        timeout_cnt  = 0;
        foreach (model[r, c]) model[r][c] = 2'd0;
        pal_model[0] = `PRU_PAL_RST0;
        pal_model[1] = `PRU_PAL_RST1;
        pal_model[2] = `PRU_PAL_RST2;
        pal_model[3] = `PRU_PAL_RST3;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        apb_transfer(1'b0, `PRU_REG_STATUS, 32'd0, rd, err);
        expect_eq("STATUS", 32'd0, rd);
        check_frame(1'b0);

        // Rectangle hanging over the right and bottom edges
        draw_shape(SHAPE_RECT, 6'd18, 6'd26, 6'd10, 6'd9, 2'd1, saw_busy);
        expect_eq("STATUS.busy", 32'd1, 32'(saw_busy));
        check_frame(1'b0);

        draw_shape(SHAPE_CIRCLE, 6'd3, 6'd4, 6'd0, 6'd6, 2'd3, saw_busy);
        check_frame(1'b0);

        // Error responses, none of which may touch the drawing
        start_draw(SHAPE_RECT, 6'd8, 6'd12, 6'd7, 6'd5, 2'd2, err);
        expect_eq("o_pslverr", 32'd0, 32'(err));
        apb_transfer(1'b1, `PRU_REG_CTRL, {29'd0, SHAPE_CLEAR, 1'b1}, rd, err);
        expect_eq("o_pslverr", 32'd1, 32'(err));
        wait_done(saw_busy);
        model_draw(SHAPE_RECT, 8, 12, 7, 5, 2'd2);
        apb_transfer(1'b1, `PRU_REG_CTRL, 32'h7, rd, err);     // Reserved shape code
        expect_eq("o_pslverr", 32'd1, 32'(err));
        apb_transfer(1'b0, `PRU_REG_CTRL, 32'd0, rd, err);
        expect_eq("CTRL", 32'd0, rd);
        apb_transfer(1'b1, 8'h14, 32'h1, rd, err);
        expect_eq("o_pslverr", 32'd1, 32'(err));
        apb_transfer(1'b0, 8'h30, 32'd0, rd, err);
        expect_eq("o_pslverr", 32'd1, 32'(err));
        check_frame(1'b0);

        // New palette, same picture, random back-pressure
        for (int i = 0; i < 4; i++) begin
            rnd          = $random(seed);
            pal_model[i] = rnd[29:0];
            apb_transfer(1'b1, 8'(`PRU_REG_PAL0 + 4 * i), {2'b00, rnd[29:0]}, rd, err);
            expect_eq("o_pslverr", 32'd0, 32'(err));
        end
        check_frame(1'b1);

        draw_shape(SHAPE_CLEAR, 6'd0, 6'd0, 6'd0, 6'd0, 2'd3, saw_busy);
        check_frame(1'b0);

        assert_cnt = pru_top_inst.pru_checker_inst.fail_cnt;
        $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatch_cnt, timeout_cnt, assert_cnt);
        if (mismatch_cnt + timeout_cnt + assert_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
pru_pkg.sv
pru_apb_regs.sv
pru_raster.sv
pru_frame_buf.sv
pru_scanout.sv
pru_top.sv
pru_checker.sv
tb_pru.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_pru -f tb.f -o tb_pru_sim \
    && ./obj_dir/tb_pru_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0
